//--- logic/isa_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction set definitions
// byte values, decoded instruction word layout
// and the opcode class rule
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package isa_pkg;

    localparam int BYTE_BITS = 8;
    typedef logic [BYTE_BITS-1:0] byte_t;

    // repeat prefix, folded into the following opcode
    localparam byte_t REP_PREFIX = 8'hF3;

    // decoded instruction word
    localparam int INSTR_WORD_BITS = 11;
    typedef logic [INSTR_WORD_BITS-1:0] instr_word_t;

    localparam int OPCODE_LSB  = 0;  // 8 bits of opcode
    localparam int MODRM_BIT   = 8;
    localparam int REP_BIT     = 9;
    localparam int INVALID_BIT = 10;

    // opcode class is the low three opcode bits
    localparam int CLASS_BITS = 3;
    typedef logic [CLASS_BITS-1:0] class_t;

    // routine length in micro-ops, (class mod 4) + 1
    function automatic logic [2:0] routine_len(class_t cls);
        return {1'b0, cls[1:0]} + 3'd1;
    endfunction

    // both top bits set is undefined, except for the prefix
    function automatic logic is_invalid(byte_t b);
        return (b[7:6] == 2'b11) && (b != REP_PREFIX);
    endfunction

endpackage

//--- logic/ucode_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// microcode definitions
// address type, fixed entry points, microword
// layout, jump types and sequencer states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ucode_pkg;

    localparam int UADDR_BITS = 7;
    typedef logic [UADDR_BITS-1:0] uaddr_t;

    // fixed addresses above the routine area
    localparam uaddr_t NEXT_INSTR_ADDR = 7'd64;  // idle wait, never emitted
    localparam uaddr_t MODRM_ADDR      = 7'd65;
    localparam uaddr_t BAD_OPCODE_ADDR = 7'd66;
    localparam uaddr_t IRQ_ADDR        = 7'd67;
    localparam uaddr_t RESET_ADDR      = 7'd68;  // never emitted

    // routines sit at class * 8
    function automatic uaddr_t class_entry(isa_pkg::class_t cls);
        return {1'b0, cls, 3'b000};
    endfunction

    localparam int JT_BITS = 3;
    typedef logic [JT_BITS-1:0] jt_t;

    localparam jt_t JT_UNCOND   = 3'd0;
    localparam jt_t JT_DISPATCH = 3'd1;  // to the class entry
    localparam jt_t JT_REP_LOOP = 3'd2;  // back to entry while repeats remain

    // microword: {ext_int_yield, next_instruction, jump_type, next}
    localparam int UWORD_BITS = 12;
    typedef logic [UWORD_BITS-1:0] uword_t;

    localparam int UW_NEXT_LSB  = 0;
    localparam int UW_JT_LSB    = 7;
    localparam int UW_NI_BIT    = 10;
    localparam int UW_YIELD_BIT = 11;

    function automatic uword_t make_uword(uaddr_t next, jt_t jt, logic ni, logic yield);
        uword_t w;
        w = '0;
        w[UW_NEXT_LSB +: UADDR_BITS] = next;
        w[UW_JT_LSB +: JT_BITS]      = jt;
        w[UW_NI_BIT]                 = ni;
        w[UW_YIELD_BIT]              = yield;
        return w;
    endfunction

    // micro-op output handshake
    typedef enum logic [1:0] {
        SEQ_IDLE,     // at a non-emitted address
        SEQ_ISSUE,    // address entered, req rises next
        SEQ_REQ,      // req high, waiting for ack
        SEQ_RELEASE   // req dropped, waiting for ack low
    } sequencer_state_e;

endpackage

//--- logic/instr_fifo_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction FIFO bus
// push side from the decoder, pop side
// to the sequencer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface instr_fifo_if;
    import isa_pkg::*;

    logic        push;     // only while full is low
    logic        full;
    instr_word_t wr_word;
    logic        pop;      // only while empty is low
    logic        empty;
    instr_word_t rd_word;  // valid whenever empty is low

    modport writer (
        output push, wr_word,
        input  full
    );

    modport buffer (
        input  push, wr_word, pop,
        output full, empty, rd_word
    );

    modport reader (
        output pop,
        input  empty, rd_word
    );

endinterface

//--- logic/byte_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte decoder
// takes instruction bytes over a four-phase
// req/ack port, folds the repeat prefix into
// the next opcode and pushes decoded words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module byte_decoder (
    input  logic          clk,
    input  logic          reset,
    input  logic          byte_req,
    input  isa_pkg::byte_t byte_data,
    output logic          byte_ack,
    instr_fifo_if.writer  fifo
);
    import isa_pkg::*;

    typedef enum logic {
        DEC_IDLE,  // waiting for a byte
        DEC_ACK    // ack high until req falls
    } dec_state_e;

    dec_state_e  state;
    logic        rep_pending;  // prefix seen and waiting for its opcode
    logic        accept;
    logic        is_prefix;
    instr_word_t word;

    // a full FIFO holds ack low, which stalls the source
    assign accept    = (state == DEC_IDLE) && byte_req && !fifo.full;
    assign is_prefix = byte_data == REP_PREFIX;

    assign fifo.push    = accept && !is_prefix;
    assign fifo.wr_word = word;
    assign byte_ack     = state == DEC_ACK;

    always_comb begin
        word = '0;
        word[OPCODE_LSB +: BYTE_BITS] = byte_data;
        word[MODRM_BIT]               = byte_data[3];
        word[REP_BIT]                 = rep_pending;
        word[INVALID_BIT]             = is_invalid(byte_data);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= DEC_IDLE;
        end else begin
            case (state)
                DEC_IDLE: begin
                    if (accept)
                        state <= DEC_ACK;
                end
                DEC_ACK: begin
                    if (!byte_req)
                        state <= DEC_IDLE;  // ack falls on this edge
                end
                default: state <= DEC_IDLE;
            endcase
        end
    end

    // a prefix sets the flag and the opcode after it consumes it
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            rep_pending <= 1'b0;
        else if (accept)
            rep_pending <= is_prefix;
    end

    a_no_push_full: assert property (
        @(posedge clk) disable iff (reset)
        fifo.push |-> !fifo.full
    ) else $error("byte_decoder pushed into a full FIFO");

endmodule

//--- logic/instr_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction FIFO
// circular buffer of decoded instruction
// words, push and pop in the same cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module instr_fifo #(
    parameter int DEPTH = 4
) (
    input  logic         clk,
    input  logic         reset,
    instr_fifo_if.buffer fifo
);
    import isa_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    instr_word_t     mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;

    // wrap at DEPTH, which need not be a power of two
    function automatic logic [AW-1:0] bump(logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign fifo.full    = count == CW'(DEPTH);
    assign fifo.empty   = count == '0;
    assign fifo.rd_word = mem[rd_ptr];  // head word, no read latency

    always_ff @(posedge clk) begin
        if (fifo.push)
            mem[wr_ptr] <= fifo.wr_word;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (fifo.push)
                wr_ptr <= bump(wr_ptr);
            if (fifo.pop)
                rd_ptr <= bump(rd_ptr);
            case ({fifo.push, fifo.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (reset)
        count <= CW'(DEPTH)
    ) else $error("instr_fifo overflow");

    a_no_underflow: assert property (
        @(posedge clk) disable iff (reset)
        fifo.pop |-> !fifo.empty
    ) else $error("instr_fifo popped while empty");

endmodule

//--- logic/microcode_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// microcode sequencer
// dispatches instruction words into the
// microcode ROM, walks each routine, repeats
// prefixed routines, takes interrupts at the
// instruction boundary and hands every micro-op
// out over a four-phase req/ack port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module microcode_sequencer #(
    parameter int REP_COUNT = 2
) (
    input  logic             clk,
    input  logic             reset,
    instr_fifo_if.reader     fifo,
    input  logic             intr,
    input  logic             int_enabled,
    output logic             inta,
    output logic             uop_req,
    input  logic             uop_ack,
    output ucode_pkg::uaddr_t uop_addr,
    output isa_pkg::byte_t   uop_opcode,
    output logic             uop_last
);
    import isa_pkg::*;
    import ucode_pkg::*;

    localparam int RW = $clog2(REP_COUNT) + 1;

    sequencer_state_e state;
    uaddr_t           addr;
    uaddr_t           next_addr;
    uaddr_t           dispatch_addr;
    uword_t           uword;
    jt_t              jt;
    instr_word_t      cur_instr;
    class_t           cur_class;
    class_t           new_class;
    logic [RW-1:0]    rep_left;     // passes still to run after this one
    logic             loop_taken;
    logic             at_wait;
    logic             take_irq;
    logic             start_instr;
    logic             irq_entry;

    // routine words run straight on, the last one loops or ends the instruction
    function automatic uword_t rom_word(uaddr_t a);
        uword_t w;
        case (a)
            7'd0:  w = make_uword(NEXT_INSTR_ADDR, JT_REP_LOOP, 1'b1, 1'b0);
            7'd8:  w = make_uword(7'd9, JT_UNCOND, 1'b0, 1'b0);
            7'd9:  w = make_uword(NEXT_INSTR_ADDR, JT_REP_LOOP, 1'b1, 1'b0);
            7'd16: w = make_uword(7'd17, JT_UNCOND, 1'b0, 1'b0);
            7'd17: w = make_uword(7'd18, JT_UNCOND, 1'b0, 1'b0);
            7'd18: w = make_uword(NEXT_INSTR_ADDR, JT_REP_LOOP, 1'b1, 1'b0);
            7'd24: w = make_uword(7'd25, JT_UNCOND, 1'b0, 1'b0);
            7'd25: w = make_uword(7'd26, JT_UNCOND, 1'b0, 1'b0);
            7'd26: w = make_uword(7'd27, JT_UNCOND, 1'b0, 1'b0);
            7'd27: w = make_uword(NEXT_INSTR_ADDR, JT_REP_LOOP, 1'b1, 1'b0);
            7'd32: w = make_uword(NEXT_INSTR_ADDR, JT_REP_LOOP, 1'b1, 1'b0);
            7'd40: w = make_uword(7'd41, JT_UNCOND, 1'b0, 1'b0);
            7'd41: w = make_uword(NEXT_INSTR_ADDR, JT_REP_LOOP, 1'b1, 1'b0);
            7'd48: w = make_uword(7'd49, JT_UNCOND, 1'b0, 1'b0);
            7'd49: w = make_uword(7'd50, JT_UNCOND, 1'b0, 1'b0);
            7'd50: w = make_uword(NEXT_INSTR_ADDR, JT_REP_LOOP, 1'b1, 1'b0);
            7'd56: w = make_uword(7'd57, JT_UNCOND, 1'b0, 1'b0);
            7'd57: w = make_uword(7'd58, JT_UNCOND, 1'b0, 1'b0);
            7'd58: w = make_uword(7'd59, JT_UNCOND, 1'b0, 1'b0);
            7'd59: w = make_uword(NEXT_INSTR_ADDR, JT_REP_LOOP, 1'b1, 1'b0);
            NEXT_INSTR_ADDR: w = make_uword(NEXT_INSTR_ADDR, JT_UNCOND, 1'b1, 1'b1);
            MODRM_ADDR:      w = make_uword(NEXT_INSTR_ADDR, JT_DISPATCH, 1'b0, 1'b0);
            BAD_OPCODE_ADDR: w = make_uword(NEXT_INSTR_ADDR, JT_UNCOND, 1'b1, 1'b0);
            IRQ_ADDR:        w = make_uword(NEXT_INSTR_ADDR, JT_UNCOND, 1'b1, 1'b0);
            default:         w = make_uword(NEXT_INSTR_ADDR, JT_UNCOND, 1'b0, 1'b0);
        endcase
        return w;
    endfunction

    assign uword     = rom_word(addr);
    assign jt        = uword[UW_JT_LSB +: JT_BITS];
    assign cur_class = cur_instr[OPCODE_LSB +: CLASS_BITS];
    assign new_class = fifo.rd_word[OPCODE_LSB +: CLASS_BITS];

    // the interrupt goes ahead of the next instruction at the boundary
    assign at_wait     = addr == NEXT_INSTR_ADDR;
    assign take_irq    = at_wait && uword[UW_YIELD_BIT] && intr && int_enabled;
    assign start_instr = at_wait && !take_irq && !fifo.empty;
    assign irq_entry   = (state == SEQ_IDLE) && take_irq;
    assign fifo.pop    = (state == SEQ_IDLE) && start_instr;

    assign loop_taken = (jt == JT_REP_LOOP) && (rep_left != '0);

    always_comb begin
        if (fifo.rd_word[INVALID_BIT])
            dispatch_addr = BAD_OPCODE_ADDR;
        else if (fifo.rd_word[MODRM_BIT])
            dispatch_addr = MODRM_ADDR;  // routine follows via JT_DISPATCH
        else
            dispatch_addr = class_entry(new_class);
    end

    always_comb begin
        case (jt)
            JT_DISPATCH: next_addr = class_entry(cur_class);
            JT_REP_LOOP: next_addr = loop_taken ? class_entry(cur_class)
                                                : uword[UW_NEXT_LSB +: UADDR_BITS];
            default:     next_addr = uword[UW_NEXT_LSB +: UADDR_BITS];
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= SEQ_IDLE;
            addr     <= RESET_ADDR;
            rep_left <= '0;
            inta     <= 1'b0;
        end else begin
            inta <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (!at_wait) begin
                        addr <= next_addr;  // reset word falls through to the wait
                    end else if (take_irq) begin
                        addr     <= IRQ_ADDR;
                        rep_left <= '0;
                        inta     <= 1'b1;
                        state    <= SEQ_ISSUE;
                    end else if (start_instr) begin
                        addr     <= dispatch_addr;
                        rep_left <= fifo.rd_word[REP_BIT] ? RW'(REP_COUNT - 1) : '0;
                        state    <= SEQ_ISSUE;
                    end
                end
                SEQ_ISSUE: state <= SEQ_REQ;
                SEQ_REQ: begin
                    if (uop_ack)
                        state <= SEQ_RELEASE;
                end
                SEQ_RELEASE: begin
                    if (!uop_ack) begin
                        addr <= next_addr;
                        if (loop_taken)
                            rep_left <= rep_left - 1'b1;
                        state <= (next_addr == NEXT_INSTR_ADDR) ? SEQ_IDLE : SEQ_ISSUE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // an interrupt carries no opcode and clears the instruction register
    always_ff @(posedge clk) begin
        if (fifo.pop)
            cur_instr <= fifo.rd_word;
        else if (irq_entry)
            cur_instr <= '0;
    end

    assign uop_req    = state == SEQ_REQ;
    assign uop_addr   = addr;
    assign uop_opcode = cur_instr[OPCODE_LSB +: BYTE_BITS];
    assign uop_last   = uword[UW_NI_BIT] && !loop_taken;  // only on the final pass

    a_addr_stable: assert property (
        @(posedge clk) disable iff (reset)
        uop_req |=> !uop_req || $stable(uop_addr)
    ) else $error("uop_addr changed while uop_req high");

endmodule

//--- logic/ucode_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// microcoded sequencer core
// byte decoder, instruction FIFO and
// microcode sequencer behind two req/ack ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ucode_core #(
    parameter int DEPTH     = 4,
    parameter int REP_COUNT = 2
) (
    input  logic              clk,
    input  logic              reset,
    // byte port
    input  logic              byte_req,
    input  isa_pkg::byte_t    byte_data,
    output logic              byte_ack,
    // interrupt
    input  logic              intr,
    input  logic              int_enabled,
    output logic              inta,
    // micro-op port
    output logic              uop_req,
    input  logic              uop_ack,
    output ucode_pkg::uaddr_t uop_addr,
    output isa_pkg::byte_t    uop_opcode,
    output logic              uop_last
);

    instr_fifo_if fifo_bus ();

    byte_decoder u_decoder (
        .clk       (clk),
        .reset     (reset),
        .byte_req  (byte_req),
        .byte_data (byte_data),
        .byte_ack  (byte_ack),
        .fifo      (fifo_bus.writer)
    );

    instr_fifo #(.DEPTH(DEPTH)) u_fifo (
        .clk   (clk),
        .reset (reset),
        .fifo  (fifo_bus.buffer)
    );

    microcode_sequencer #(.REP_COUNT(REP_COUNT)) u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .fifo        (fifo_bus.reader),
        .intr        (intr),
        .int_enabled (int_enabled),
        .inta        (inta),
        .uop_req     (uop_req),
        .uop_ack     (uop_ack),
        .uop_addr    (uop_addr),
        .uop_opcode  (uop_opcode),
        .uop_last    (uop_last)
    );

endmodule

//--- bench/ucode_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the microcoded sequencer core
// table of byte sequences sent over the byte port,
// a randomly delayed micro-op sink and a reference
// model of the expected micro-op stream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ucode_tb;

    localparam int MAX_TESTS = 8;
    localparam int REPS      = 2;  // default repeat count of the core
    localparam logic [7:0] REP_BYTE = 8'hF3;
    localparam logic [6:0] MODRM_A  = 7'd65;
    localparam logic [6:0] BAD_A    = 7'd66;
    localparam logic [6:0] IRQ_A    = 7'd67;

    logic       clk;
    logic       reset;
    logic       byte_req;
    logic [7:0] byte_data;
    logic       byte_ack;
    logic       intr;
    logic       int_enabled;
    logic       inta;
    logic       uop_req;
    logic       uop_ack;
    logic [6:0] uop_addr;
    logic [7:0] uop_opcode;
    logic       uop_last;

    // test table with the first byte in the top bits of the sequence
    string       test_name [MAX_TESTS];
    int          test_len  [MAX_TESTS];
    logic [63:0] test_seq  [MAX_TESTS];
    bit          test_intr [MAX_TESTS];
    bit          test_ien  [MAX_TESTS];
    int          test_dmin [MAX_TESTS];
    int          test_dmax [MAX_TESTS];
    bit          test_stall[MAX_TESTS];  // burst expected to hit a full FIFO
    int          num_tests;
    bit          table_ready;

    logic [15:0] exp_q[$];  // {addr, opcode, last}
    string       cur_name;
    int          sink_dmin;
    int          sink_dmax;
    int          errors;
    int          checks;
    int          inta_count;
    int          max_stall;
    int unsigned seed_val;

    ucode_core dut (
        .clk         (clk),
        .reset       (reset),
        .byte_req    (byte_req),
        .byte_data   (byte_data),
        .byte_ack    (byte_ack),
        .intr        (intr),
        .int_enabled (int_enabled),
        .inta        (inta),
        .uop_req     (uop_req),
        .uop_ack     (uop_ack),
        .uop_addr    (uop_addr),
        .uop_opcode  (uop_opcode),
        .uop_last    (uop_last)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [15:0] pack_uop(logic [6:0] a, logic [7:0] op, logic last);
        return {a, op, last};
    endfunction

    function automatic string uop_text(logic [15:0] v);
        return $sformatf("addr=%0d op=%h last=%b", v[15:9], v[8:1], v[0]);
    endfunction

    task automatic add_row(input string name, input int len, input logic [63:0] seq,
                           input bit irq, input bit ien, input int dmin, input int dmax,
                           input bit stall);
        test_name[num_tests]  = name;
        test_len[num_tests]   = len;
        test_seq[num_tests]   = seq;
        test_intr[num_tests]  = irq;
        test_ien[num_tests]   = ien;
        test_dmin[num_tests]  = dmin;
        test_dmax[num_tests]  = dmax;
        test_stall[num_tests] = stall;
        num_tests++;
    endtask

    // reference model of the micro-op stream for one row
    task automatic build_expected(input int t);
        logic [7:0] b;
        logic       rep;
        logic [2:0] cls;
        int         len;
        int         passes;
        rep = 1'b0;
        exp_q.delete();
        if (test_intr[t] && test_ien[t])
            exp_q.push_back(pack_uop(IRQ_A, 8'h00, 1'b1));  // irq carries no opcode
        for (int k = 0; k < test_len[t]; k++) begin
            b = test_seq[t][63 - 8*k -: 8];
            if (b == REP_BYTE) begin
                rep = 1'b1;
            end else if (b[7:6] == 2'b11) begin
                exp_q.push_back(pack_uop(BAD_A, b, 1'b1));
                rep = 1'b0;
            end else begin
                cls    = b[2:0];
                len    = int'(cls[1:0]) + 1;
                passes = rep ? REPS : 1;
                if (b[3])
                    exp_q.push_back(pack_uop(MODRM_A, b, 1'b0));
                for (int p = 0; p < passes; p++) begin
                    for (int u = 0; u < len; u++) begin
                        exp_q.push_back(pack_uop(7'(int'(cls) * 8 + u), b,
                                                 (p == passes - 1) && (u == len - 1)));
                    end
                end
                rep = 1'b0;
            end
        end
    endtask

    // four-phase source that records the longest wait for ack
    task automatic send_byte(input logic [7:0] b);
        int wait_cycles;
        wait_cycles = 0;
        byte_data = b;
        byte_req  = 1'b1;
        @(negedge clk);
        while (!byte_ack) begin
            wait_cycles++;
            @(negedge clk);
        end
        if (wait_cycles > max_stall)
            max_stall = wait_cycles;
        byte_req = 1'b0;
        while (byte_ack)
            @(negedge clk);
    endtask

    // micro-op sink with random ack delay
    initial begin
        logic [15:0] exp_v;
        logic [15:0] act_v;
        int          d;
        seed_val = $urandom(58);
        @(negedge reset);
        forever begin
            @(negedge clk);
            if (uop_req && !uop_ack) begin
                d = sink_dmin + int'($urandom % 32'(sink_dmax - sink_dmin + 1));
                repeat (d) @(negedge clk);
                act_v = {uop_addr, uop_opcode, uop_last};
                checks++;
                if (exp_q.size() == 0) begin
                    $display("%s: unexpected micro-op %s", cur_name, uop_text(act_v));
                    errors++;
                end else begin
                    exp_v = exp_q.pop_front();
                    if (act_v != exp_v) begin
                        $display("MISMATCH %s: expected %s, actual %s",
                                 cur_name, uop_text(exp_v), uop_text(act_v));
                        errors++;
                    end
                end
                uop_ack = 1'b1;
                while (uop_req)
                    @(negedge clk);
                uop_ack = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (inta)
            inta_count++;  // one cycle wide so seen once
    end

    task automatic run_test(input int t);
        int err_start;
        int inta_start;
        int n_uops;
        err_start  = errors;
        inta_start = inta_count;
        max_stall  = 0;
        cur_name   = test_name[t];
        sink_dmin  = test_dmin[t];
        sink_dmax  = test_dmax[t];
        build_expected(t);
        n_uops = exp_q.size();
        if (test_intr[t]) begin
            intr        = 1'b1;
            int_enabled = test_ien[t];
            @(negedge clk);
            if (test_ien[t]) begin
                while (!inta)
                    @(negedge clk);
                intr = 1'b0;  // one interrupt only
            end
        end
        for (int k = 0; k < test_len[t]; k++)
            send_byte(test_seq[t][63 - 8*k -: 8]);
        while (exp_q.size() != 0 || uop_req || uop_ack)
            @(negedge clk);
        repeat (12) @(negedge clk);  // room for stray micro-ops
        checks++;
        if (inta_count - inta_start != ((test_intr[t] && test_ien[t]) ? 1 : 0)) begin
            $display("%s: wrong number of inta pulses (%0d)", cur_name,
                     inta_count - inta_start);
            errors++;
        end
        if (test_stall[t]) begin
            checks++;
            if (max_stall < 4) begin
                $display("%s: byte_ack never held off by a full FIFO", cur_name);
                errors++;
            end
        end
        intr        = 1'b0;
        int_enabled = 1'b0;
        $display("test %-20s %s (%0d micro-ops)", cur_name,
                 (errors == err_start) ? "PASS" : "FAIL", n_uops);
    endtask

    initial begin
        byte_req    = 1'b0;
        byte_data   = 8'h00;
        intr        = 1'b0;
        int_enabled = 1'b0;
        uop_ack     = 1'b0;
        reset       = 1'b1;
        errors      = 0;
        checks      = 0;
        inta_count  = 0;
        num_tests   = 0;
        add_row("class_0_to_3", 4, 64'h00010203_00000000, 0, 0, 0, 2, 0);
        add_row("class_4_to_7", 4, 64'h04050607_00000000, 0, 0, 0, 3, 0);
        add_row("modrm", 1, 64'h0A000000_00000000, 0, 0, 1, 3, 0);
        add_row("bad_opcode", 2, 64'hC5120000_00000000, 0, 0, 0, 2, 0);
        add_row("rep_prefix", 4, 64'hF302F30B_00000000, 0, 0, 0, 2, 0);
        add_row("burst_backpressure", 8, 64'h03132333_43536307, 0, 0, 6, 10, 1);
        add_row("irq_enabled", 1, 64'h01000000_00000000, 1, 1, 0, 2, 0);
        add_row("irq_masked", 1, 64'h01000000_00000000, 1, 0, 0, 2, 0);
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int t = 0; t < num_tests; t++)
            run_test(t);
        $display("%0d tests, %0d checks, %0d errors", num_tests, checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    // limit scaled by the total number of table bytes
    initial begin
        int total;
        total = 0;
        wait (table_ready);
        for (int t = 0; t < num_tests; t++)
            total += test_len[t];
        repeat (total * 200) @(posedge clk);
        $display("timeout in test %s, the core stopped making progress", cur_name);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- tb.f
logic/isa_pkg.sv
logic/ucode_pkg.sv
logic/instr_fifo_if.sv
logic/byte_decoder.sv
logic/instr_fifo.sv
logic/microcode_sequencer.sv
logic/ucode_core.sv
bench/ucode_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= ucode_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
